/* design/dbus_params.svh */
`ifndef DBUS_PARAMS_SVH
`define DBUS_PARAMS_SVH

// Bus widths
`define DBUS_ADDR_WIDTH     32
`define DBUS_DATA_WIDTH     32
`define DBUS_SEL_WIDTH      (`DBUS_DATA_WIDTH/8)   // One enable per byte lane

// Address field that picks the device
`define DEV_SEL_ADDR_HIGH   31
`define DEV_SEL_ADDR_LOW    28

// Device match values for the select field
`define DMEM_ADDR_MATCH     4'h8
`define GPIO_ADDR_MATCH     4'h4

// Data memory geometry
`define DMEM_DEPTH_WORDS    256
`define DMEM_IDX_HIGH       9     // Word index taken from addr[9:2]
`define DMEM_IDX_LOW        2

`endif

/* design/lsu_ops_pkg.sv */
package lsu_ops_pkg;

    // Store operations from the load-store unit
    typedef enum logic [1:0] {
        ST_OPS_NONE = 2'd0,
        ST_OPS_SB   = 2'd1,
        ST_OPS_SH   = 2'd2,
        ST_OPS_SW   = 2'd3
    } st_ops_e;

    // Load operations, signed and unsigned variants
    typedef enum logic [2:0] {
        LD_OPS_NONE = 3'd0,
        LD_OPS_LB   = 3'd1,
        LD_OPS_LH   = 3'd2,
        LD_OPS_LW   = 3'd3,
        LD_OPS_LBU  = 3'd4,
        LD_OPS_LHU  = 3'd5
    } ld_ops_e;

endpackage : lsu_ops_pkg

/* design/dbus_pkg.sv */
`include "dbus_params.svh"

package dbus_pkg;

    // Plain bus vectors
    typedef logic [`DBUS_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DBUS_DATA_WIDTH-1:0] data_t;
    typedef logic [`DBUS_SEL_WIDTH-1:0]  sel_byte_t;  // Bit k enables data[8k+7:8k]

    // Device that owns the response one cycle after the request
    typedef enum logic [1:0] {
        DEV_NONE = 2'b00,
        DEV_DMEM = 2'b01,
        DEV_GPIO = 2'b10
    } dev_t;

endpackage : dbus_pkg

/* design/dbus_interconnect.sv */
`timescale 1ns/1ns
`include "dbus_params.svh"

module dbus_interconnect (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  ld_req_i,
    input  logic                  st_req_i,
    input  dbus_pkg::addr_t       addr_i,
    input  dbus_pkg::data_t       w_data_i,
    input  lsu_ops_pkg::st_ops_e  st_ops_i,
    input  lsu_ops_pkg::ld_ops_e  ld_ops_i,
    input  dbus_pkg::data_t       dmem_r_data_i,
    input  dbus_pkg::data_t       gpio_r_data_i,
    output dbus_pkg::addr_t       bus_addr_o,
    output dbus_pkg::data_t       bus_w_data_o,
    output dbus_pkg::sel_byte_t   bus_sel_byte_o,
    output logic                  bus_w_en_o,
    output logic                  dmem_sel_o,
    output logic                  gpio_sel_o,
    output dbus_pkg::data_t       resp_data_o,
    output logic                  resp_ld_o,
    output logic                  resp_err_o,
    output lsu_ops_pkg::ld_ops_e  resp_ld_ops_o,
    output logic [1:0]            resp_byte_off_o,
    output logic                  bus_err_o
);

    logic                  req;
    logic                  dmem_match;
    logic                  gpio_match;
    logic                  map_err;
    dbus_pkg::dev_t        dev_d;
    dbus_pkg::dev_t        dev_q;
    logic                  ld_q;
    logic                  err_q;
    logic                  err_qq;
    lsu_ops_pkg::ld_ops_e  ld_ops_q;
    logic [1:0]            byte_off_q;

    assign req        = ld_req_i | st_req_i;
    assign dmem_match = (addr_i[`DEV_SEL_ADDR_HIGH:`DEV_SEL_ADDR_LOW] == `DMEM_ADDR_MATCH);
    assign gpio_match = (addr_i[`DEV_SEL_ADDR_HIGH:`DEV_SEL_ADDR_LOW] == `GPIO_ADDR_MATCH);

    // Priority decode, dmem wins
    assign dmem_sel_o = req & dmem_match;
    assign gpio_sel_o = req & ~dmem_match & gpio_match;
    assign map_err    = req & ~dmem_match & ~gpio_match;

    assign bus_addr_o = addr_i;
    assign bus_w_en_o = st_req_i & (dmem_sel_o | gpio_sel_o);  // No write to unmapped space

    // Place store data on its lanes
    always_comb begin
        bus_w_data_o   = '0;
        bus_sel_byte_o = '0;
        case (st_ops_i)
            lsu_ops_pkg::ST_OPS_SB: begin
                bus_w_data_o[8*addr_i[1:0] +: 8] = w_data_i[7:0];
                bus_sel_byte_o[addr_i[1:0]]      = 1'b1;
            end
            lsu_ops_pkg::ST_OPS_SH: begin
                if (addr_i[1]) begin  // Upper half, bit 0 ignored
                    bus_w_data_o[31:16] = w_data_i[15:0];
                    bus_sel_byte_o      = 4'b1100;
                end else begin
                    bus_w_data_o[15:0] = w_data_i[15:0];
                    bus_sel_byte_o     = 4'b0011;
                end
            end
            lsu_ops_pkg::ST_OPS_SW: begin
                bus_w_data_o   = w_data_i;
                bus_sel_byte_o = 4'b1111;
            end
            default: ;
        endcase
    end

    always_comb begin
        if (dmem_sel_o) dev_d = dbus_pkg::DEV_DMEM;
        else if (gpio_sel_o) dev_d = dbus_pkg::DEV_GPIO;
        else dev_d = dbus_pkg::DEV_NONE;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dev_q  <= dbus_pkg::DEV_NONE;
            ld_q   <= 1'b0;
            err_q  <= 1'b0;
            err_qq <= 1'b0;
        end else begin
            dev_q  <= dev_d;
            ld_q   <= ld_req_i;
            err_q  <= map_err;
            err_qq <= err_q;  // Second stage for the bus error pulse
        end
    end

    // Load details travel with the response
    always_ff @(posedge clk) begin
        ld_ops_q   <= ld_ops_i;
        byte_off_q <= addr_i[1:0];
    end

    // Steer the returning word by the registered owner
    always_comb begin
        case (dev_q)
            dbus_pkg::DEV_DMEM: resp_data_o = dmem_r_data_i;
            dbus_pkg::DEV_GPIO: resp_data_o = gpio_r_data_i;
            default:            resp_data_o = '0;
        endcase
    end

    assign resp_ld_o       = ld_q;
    assign resp_err_o      = err_q;
    assign resp_ld_ops_o   = ld_ops_q;
    assign resp_byte_off_o = byte_off_q;
    assign bus_err_o       = err_qq;

    assert property (@(posedge clk) disable iff (!arst_n_i) !(ld_req_i && st_req_i))
        else $error("dbus: load and store requested in the same cycle");

    // A load strobe must name its load type
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     ld_req_i |-> (ld_ops_i != lsu_ops_pkg::LD_OPS_NONE))
        else $error("dbus: load requested without a load operation");

endmodule : dbus_interconnect

/* design/data_mem.sv */
`timescale 1ns/1ns
`include "dbus_params.svh"

module data_mem (
    input  logic                 clk,
    input  logic                 sel_i,
    input  logic                 w_en_i,
    input  dbus_pkg::addr_t      addr_i,
    input  dbus_pkg::data_t      w_data_i,
    input  dbus_pkg::sel_byte_t  sel_byte_i,
    output dbus_pkg::data_t      r_data_o
);

    dbus_pkg::data_t                        mem [`DMEM_DEPTH_WORDS];
    logic [`DMEM_IDX_HIGH-`DMEM_IDX_LOW:0]  word_idx;

    assign word_idx = addr_i[`DMEM_IDX_HIGH:`DMEM_IDX_LOW];

    // Byte-lane write
    always_ff @(posedge clk) begin
        if (sel_i && w_en_i) begin
            for (int k = 0; k < `DBUS_SEL_WIDTH; k++) begin
                if (sel_byte_i[k]) begin
                    mem[word_idx][8*k +: 8] <= w_data_i[8*k +: 8];
                end
            end
        end
    end

    // Registered read, held between reads
    always_ff @(posedge clk) begin
        if (sel_i && !w_en_i) begin
            r_data_o <= mem[word_idx];
        end
    end

    // Interconnect must send at least one lane with every write
    assert property (@(posedge clk) (sel_i && w_en_i) |-> (sel_byte_i != '0))
        else $error("data_mem: selected write with no byte lanes");

endmodule : data_mem

/* design/gpio_regs.sv */
`timescale 1ns/1ns
`include "dbus_params.svh"

module gpio_regs (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 sel_i,
    input  logic                 w_en_i,
    input  dbus_pkg::data_t      w_data_i,
    input  dbus_pkg::sel_byte_t  sel_byte_i,
    output dbus_pkg::data_t      r_data_o,
    output dbus_pkg::data_t      gpio_o
);

    dbus_pkg::data_t gpio_q;  // Output pin register

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gpio_q <= '0;
        end else if (sel_i && w_en_i) begin
            for (int k = 0; k < `DBUS_SEL_WIDTH; k++) begin
                if (sel_byte_i[k]) gpio_q[8*k +: 8] <= w_data_i[8*k +: 8];
            end
        end
    end

    // Readback
    always_ff @(posedge clk) begin
        if (sel_i && !w_en_i) begin
            r_data_o <= gpio_q;
        end
    end

    assign gpio_o = gpio_q;

endmodule : gpio_regs

/* design/load_align.sv */
`timescale 1ns/1ns

module load_align (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  resp_ld_i,
    input  logic                  resp_err_i,
    input  dbus_pkg::data_t       resp_data_i,
    input  lsu_ops_pkg::ld_ops_e  resp_ld_ops_i,
    input  logic [1:0]            resp_byte_off_i,
    output dbus_pkg::data_t       r_data_o,
    output logic                  ld_valid_o
);

    logic [7:0]       byte_val;
    logic [15:0]      half_val;
    dbus_pkg::data_t  result;

    assign byte_val = resp_data_i[8*resp_byte_off_i +: 8];
    assign half_val = resp_byte_off_i[1] ? resp_data_i[31:16] : resp_data_i[15:0];

    // Extend by load type
    always_comb begin
        case (resp_ld_ops_i)
            lsu_ops_pkg::LD_OPS_LB:  result = {{24{byte_val[7]}}, byte_val};
            lsu_ops_pkg::LD_OPS_LBU: result = {24'h0, byte_val};
            lsu_ops_pkg::LD_OPS_LH:  result = {{16{half_val[15]}}, half_val};
            lsu_ops_pkg::LD_OPS_LHU: result = {16'h0, half_val};
            lsu_ops_pkg::LD_OPS_LW:  result = resp_data_i;
            default:                 result = '0;
        endcase
        if (resp_err_i) result = '0;  // Unmapped load returns zero
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) ld_valid_o <= 1'b0;
        else ld_valid_o <= resp_ld_i;
    end

    always_ff @(posedge clk) begin
        if (resp_ld_i) r_data_o <= result;
    end

endmodule : load_align

/* design/dbus_subsys.sv */
`timescale 1ns/1ns

module dbus_subsys (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  ld_req_i,
    input  logic                  st_req_i,
    input  dbus_pkg::addr_t       addr_i,
    input  dbus_pkg::data_t       w_data_i,
    input  lsu_ops_pkg::ld_ops_e  ld_ops_i,
    input  lsu_ops_pkg::st_ops_e  st_ops_i,
    output dbus_pkg::data_t       r_data_o,
    output logic                  ld_valid_o,
    output logic                  bus_err_o,
    output dbus_pkg::data_t       gpio_o
);

    // Shared bus towards the devices
    dbus_pkg::addr_t       bus_addr;
    dbus_pkg::data_t       bus_w_data;
    dbus_pkg::sel_byte_t   bus_sel_byte;
    logic                  bus_w_en;
    logic                  dmem_sel;
    logic                  gpio_sel;
    dbus_pkg::data_t       dmem_r_data;
    dbus_pkg::data_t       gpio_r_data;

    // Response path into load return
    dbus_pkg::data_t       resp_data;
    logic                  resp_ld;
    logic                  resp_err;
    lsu_ops_pkg::ld_ops_e  resp_ld_ops;
    logic [1:0]            resp_byte_off;

    dbus_interconnect dbus_interconnect_i (
        .clk(clk), .arst_n_i(arst_n_i),
        .ld_req_i(ld_req_i), .st_req_i(st_req_i), .addr_i(addr_i), .w_data_i(w_data_i),
        .st_ops_i(st_ops_i), .ld_ops_i(ld_ops_i),
        .dmem_r_data_i(dmem_r_data), .gpio_r_data_i(gpio_r_data),
        .bus_addr_o(bus_addr), .bus_w_data_o(bus_w_data), .bus_sel_byte_o(bus_sel_byte),
        .bus_w_en_o(bus_w_en), .dmem_sel_o(dmem_sel), .gpio_sel_o(gpio_sel),
        .resp_data_o(resp_data), .resp_ld_o(resp_ld), .resp_err_o(resp_err),
        .resp_ld_ops_o(resp_ld_ops), .resp_byte_off_o(resp_byte_off), .bus_err_o(bus_err_o)
    );

    data_mem data_mem_i (
        .clk(clk), .sel_i(dmem_sel), .w_en_i(bus_w_en), .addr_i(bus_addr),
        .w_data_i(bus_w_data), .sel_byte_i(bus_sel_byte), .r_data_o(dmem_r_data)
    );

    gpio_regs gpio_regs_i (
        .clk(clk), .arst_n_i(arst_n_i), .sel_i(gpio_sel), .w_en_i(bus_w_en),
        .w_data_i(bus_w_data), .sel_byte_i(bus_sel_byte),
        .r_data_o(gpio_r_data), .gpio_o(gpio_o)
    );

    load_align load_align_i (
        .clk(clk), .arst_n_i(arst_n_i), .resp_ld_i(resp_ld), .resp_err_i(resp_err),
        .resp_data_i(resp_data), .resp_ld_ops_i(resp_ld_ops),
        .resp_byte_off_i(resp_byte_off), .r_data_o(r_data_o), .ld_valid_o(ld_valid_o)
    );

endmodule : dbus_subsys

/* tests/tb_dbus_subsys.sv */
`timescale 1ns/1ns

module tb_dbus_subsys;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_LINES    = 500;
    localparam int DRAIN_LIMIT  = 10;

    // Expected response of one request, checked in cycle due
    typedef struct packed {
        logic [127:0]     name;
        int               due;
        logic             is_ld;
        logic             err;
        dbus_pkg::data_t  r_data;
        dbus_pkg::data_t  gpio;
    } expect_t;

    logic                  clk;
    logic                  arst_n_i;
    logic                  ld_req_i;
    logic                  st_req_i;
    dbus_pkg::addr_t       addr_i;
    dbus_pkg::data_t       w_data_i;
    lsu_ops_pkg::ld_ops_e  ld_ops_i;
    lsu_ops_pkg::st_ops_e  st_ops_i;
    dbus_pkg::data_t       r_data_o;
    logic                  ld_valid_o;
    logic                  bus_err_o;
    dbus_pkg::data_t       gpio_o;

    expect_t gpio_pend [$];  // Due one cycle after the request
    expect_t resp_pend [$];  // Due two cycles after the request

    dbus_subsys dbus_subsys_i (
        .clk(clk), .arst_n_i(arst_n_i), .ld_req_i(ld_req_i), .st_req_i(st_req_i),
        .addr_i(addr_i), .w_data_i(w_data_i), .ld_ops_i(ld_ops_i), .st_ops_i(st_ops_i),
        .r_data_o(r_data_o), .ld_valid_o(ld_valid_o), .bus_err_o(bus_err_o), .gpio_o(gpio_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic flag_wrong_value(input logic [127:0] name, input string what,
                                    input logic [31:0] exp, input logic [31:0] act);
        abort_run($sformatf("mismatch in %0s: %s expected %h actual %h", name, what, exp, act));
    endtask

    // Outputs are registered, so they are stable at the falling edge
    task automatic check_due(input int cyc);
        expect_t e;
        if (gpio_pend.size() > 0 && gpio_pend[0].due == cyc) begin
            e = gpio_pend.pop_front();
            assert (gpio_o === e.gpio)
                else flag_wrong_value(e.name, "gpio_o", e.gpio, gpio_o);
        end
        if (resp_pend.size() > 0 && resp_pend[0].due == cyc) begin
            e = resp_pend.pop_front();
            assert (ld_valid_o === e.is_ld)
                else flag_wrong_value(e.name, "ld_valid_o", 32'(e.is_ld), 32'(ld_valid_o));
            assert (bus_err_o === e.err)
                else flag_wrong_value(e.name, "bus_err_o", 32'(e.err), 32'(bus_err_o));
            if (e.is_ld) begin
                assert (r_data_o === e.r_data)
                    else flag_wrong_value(e.name, "r_data_o", e.r_data, r_data_o);
            end
        end
    endtask

    task automatic drive_request(input logic [31:0] kind, input logic [31:0] op,
                                 input dbus_pkg::addr_t addr, input dbus_pkg::data_t wdata);
        if (kind != 32'("LD") && kind != 32'("ST") && kind != 32'("NOP"))
            abort_run("unknown request kind in the test data");
        ld_req_i = (kind == 32'("LD"));
        st_req_i = (kind == 32'("ST"));
        addr_i   = addr;
        w_data_i = wdata;
        ld_ops_i = lsu_ops_pkg::LD_OPS_NONE;
        st_ops_i = lsu_ops_pkg::ST_OPS_NONE;
        case (op)
            32'("SB"):  st_ops_i = lsu_ops_pkg::ST_OPS_SB;
            32'("SH"):  st_ops_i = lsu_ops_pkg::ST_OPS_SH;
            32'("SW"):  st_ops_i = lsu_ops_pkg::ST_OPS_SW;
            32'("LB"):  ld_ops_i = lsu_ops_pkg::LD_OPS_LB;
            32'("LH"):  ld_ops_i = lsu_ops_pkg::LD_OPS_LH;
            32'("LW"):  ld_ops_i = lsu_ops_pkg::LD_OPS_LW;
            32'("LBU"): ld_ops_i = lsu_ops_pkg::LD_OPS_LBU;
            32'("LHU"): ld_ops_i = lsu_ops_pkg::LD_OPS_LHU;
            32'("-"):   ;  // Idle cycle
            default:    abort_run("unknown operation in the test data");
        endcase
    endtask

    initial begin
        int               fd;
        int               cyc;
        int               lines;
        int               fields;
        int               drain;
        string            line;
        expect_t          e;
        logic [127:0]     name;
        logic [31:0]      kind;
        logic [31:0]      op;
        dbus_pkg::addr_t  addr;
        dbus_pkg::data_t  wdata;
        dbus_pkg::data_t  exp_r_data;
        logic             exp_err;
        dbus_pkg::data_t  exp_gpio;

        arst_n_i = 1'b0;
        drive_request(32'("NOP"), 32'("-"), '0, '0);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        assert (gpio_o === '0 && ld_valid_o === 1'b0 && bus_err_o === 1'b0)
            else abort_run("outputs were not cleared by reset");
        arst_n_i = 1'b1;

        fd = $fopen("tests/dbus_testdata.txt", "r");
        if (fd == 0) abort_run("cannot open tests/dbus_testdata.txt");
        cyc   = 0;
        lines = 0;
        while (!$feof(fd)) begin
            lines++;
            if (lines > MAX_LINES) abort_run("test data has more lines than allowed");
            void'($fgets(line, fd));
            if (line.len() < 4 || line.getc(0) == "#") continue;  // Blank or comment
            fields = $sscanf(line, "%s %s %s %h %h %h %h %h", name, kind, op, addr, wdata,
                             exp_r_data, exp_err, exp_gpio);
            if (fields != 8) abort_run($sformatf("malformed test data line: %s", line));
            @(negedge clk);
            check_due(cyc);
            drive_request(kind, op, addr, wdata);
            e.name   = name;
            e.is_ld  = (kind == 32'("LD"));
            e.err    = exp_err;
            e.r_data = exp_r_data;
            e.gpio   = exp_gpio;
            e.due    = cyc + 1;
            gpio_pend.push_back(e);
            e.due    = cyc + 2;
            resp_pend.push_back(e);
            cyc++;
        end
        $fclose(fd);

        // Let the last requests leave the pipeline
        drain = 0;
        while (gpio_pend.size() > 0 || resp_pend.size() > 0) begin
            if (drain == DRAIN_LIMIT) abort_run("expected results never arrived");
            @(negedge clk);
            check_due(cyc);
            drive_request(32'("NOP"), 32'("-"), '0, '0);
            cyc++;
            drain++;
        end
        $display(">>> PASS");
        $finish;
    end

endmodule : tb_dbus_subsys

/* tests/dbus_testdata.txt */
# name kind(LD/ST/NOP) op address wdata exp_r_data exp_err exp_gpio, values in hex
# One request per cycle; exp_r_data counts for loads only, exp_gpio is seen one cycle later
idle_a   NOP -   00000000 00000000 00000000 0 00000000
idle_b   NOP -   00000000 00000000 00000000 0 00000000
sw_a     ST  SW  80000000 12345678 00000000 0 00000000
lw_a     LD  LW  80000000 00000000 12345678 0 00000000
sw_b     ST  SW  800003fc a5a55a5a 00000000 0 00000000
lw_b     LD  LW  800003fc 00000000 a5a55a5a 0 00000000
lw_a2    LD  LW  80000000 00000000 12345678 0 00000000
sw_m     ST  SW  80000010 00000000 00000000 0 00000000
sb_m1    ST  SB  80000011 12345677 00000000 0 00000000
sb_m3    ST  SB  80000013 000000c4 00000000 0 00000000
lw_mb    LD  LW  80000010 00000000 c4007700 0 00000000
sh_m0    ST  SH  80000011 9999beef 00000000 0 00000000
lw_mh    LD  LW  80000010 00000000 c400beef 0 00000000
lh_0     LD  LH  80000010 00000000 ffffbeef 0 00000000
lh_1     LD  LH  80000011 00000000 ffffbeef 0 00000000
lh_2     LD  LH  80000012 00000000 ffffc400 0 00000000
lh_3     LD  LH  80000013 00000000 ffffc400 0 00000000
lhu_0    LD  LHU 80000010 00000000 0000beef 0 00000000
lhu_1    LD  LHU 80000011 00000000 0000beef 0 00000000
lhu_2    LD  LHU 80000012 00000000 0000c400 0 00000000
lhu_3    LD  LHU 80000013 00000000 0000c400 0 00000000
sw_s     ST  SW  80000030 12fe7f81 00000000 0 00000000
lb_0     LD  LB  80000030 00000000 ffffff81 0 00000000
lb_1     LD  LB  80000031 00000000 0000007f 0 00000000
lb_2     LD  LB  80000032 00000000 fffffffe 0 00000000
lb_3     LD  LB  80000033 00000000 00000012 0 00000000
lbu_0    LD  LBU 80000030 00000000 00000081 0 00000000
lbu_1    LD  LBU 80000031 00000000 0000007f 0 00000000
lbu_2    LD  LBU 80000032 00000000 000000fe 0 00000000
lbu_3    LD  LBU 80000033 00000000 00000012 0 00000000
sh_s2    ST  SH  80000033 ffff8001 00000000 0 00000000
lw_s     LD  LW  80000030 00000000 80017f81 0 00000000
gp_sw    ST  SW  40000000 11223344 00000000 0 11223344
gp_sb    ST  SB  40000002 000000aa 00000000 0 11aa3344
gp_sh    ST  SH  40000000 0000beef 00000000 0 11aabeef
gp_lw    LD  LW  40000004 00000000 11aabeef 0 11aabeef
gp_lbu   LD  LBU 40000003 00000000 00000011 0 11aabeef
bad_st   ST  SW  00000010 deadbeef 00000000 1 11aabeef
bad_ld   LD  LW  20000010 00000000 00000000 1 11aabeef
bad_gst  ST  SB  c0000000 000000ff 00000000 1 11aabeef
lw_keep  LD  LW  80000010 00000000 c400beef 0 11aabeef
gp_keep  LD  LW  40000000 00000000 11aabeef 0 11aabeef
idle_c   NOP -   00000000 00000000 00000000 0 11aabeef

/* files.f */
+incdir+design
design/lsu_ops_pkg.sv
design/dbus_pkg.sv
design/dbus_interconnect.sv
design/data_mem.sv
design/gpio_regs.sv
design/load_align.sv
design/dbus_subsys.sv
tests/tb_dbus_subsys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dbus_subsys
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
